// File: include/mm_dma_defs.svh
`ifndef MM_DMA_DEFS_SVH
`define MM_DMA_DEFS_SVH

// matrix geometry
`define MM_DIM          4
`define MM_WORD_W       32
`define MM_RESULTS      16
`define MM_GROUPS       8

// controller port
`define SDRAM_ADDR_W    23

// byte steps in SDRAM
`define A_ELEM_STRIDE   4
`define B_ELEM_STRIDE   16
`define A_ROW_STRIDE    16
`define B_COL_STRIDE    4

// register decode
`define REG_RESULT_BASE 8'h0C
`define REG_ADDR_LSB_W  8

`endif

// File: design/mm_dma_pkg.sv
package mm_dma_pkg;

`include "mm_dma_defs.svh"

    typedef logic signed [`MM_WORD_W-1:0] word_t;

    // one A row or B column, element 0 in the low word
    typedef word_t [`MM_DIM-1:0] word_vec_t;

    typedef enum logic [1:0] {
        HOST_IDLE,
        HOST_RUN,
        HOST_DONE
    } host_state_e;

    typedef enum logic [`REG_ADDR_LSB_W-1:0] {
        REG_CTRL   = 8'h00,  // start on write, status on read
        REG_BASE_A = 8'h04,
        REG_BASE_B = 8'h08
    } reg_offset_e;

endpackage

// File: design/sdram_req_pkg.sv
package sdram_req_pkg;

`include "mm_dma_defs.svh"

    typedef logic [`SDRAM_ADDR_W-1:0] sdram_addr_t;  // controller address bus

    typedef enum logic [2:0] {
        FETCH_IDLE,
        FETCH_WAIT_ENGINE,
        FETCH_ISSUE,
        FETCH_WAIT_DATA,
        FETCH_DONE
    } fetch_state_e;

endpackage

// File: design/wb_ctrl_regs.sv
`timescale 1ns/100ps
`include "mm_dma_defs.svh"

module wb_ctrl_regs (
    input  logic                       wb_clk_i,
    input  logic                       wb_rst_i,
    input  logic                       wbs_stb_i,
    input  logic                       wbs_cyc_i,
    input  logic                       wbs_we_i,
    input  logic [31:0]                wbs_adr_i,
    input  mm_dma_pkg::word_t          wbs_dat_i,
    input  logic                       res_valid_i,
    input  mm_dma_pkg::word_t          res_data_i,
    output logic                       wbs_ack_o,
    output logic [31:0]                wbs_dat_o,
    output logic                       start_o,
    output sdram_req_pkg::sdram_addr_t base_a_o,
    output sdram_req_pkg::sdram_addr_t base_b_o
);
    import mm_dma_pkg::*;
    import sdram_req_pkg::*;

    localparam int RES_IDX_W = $clog2(`MM_RESULTS);

    host_state_e                state_q;
    reg_offset_e                reg_sel;
    logic                       req;
    logic                       wr_req;
    logic                       rd_req;
    logic                       start_ok;
    logic                       res_wr;
    logic                       base_a_set_q;
    logic                       base_b_set_q;
    sdram_addr_t                base_a_q;
    sdram_addr_t                base_b_q;
    logic [RES_IDX_W-1:0]       res_idx_q;
    word_t                      res_mem [`MM_RESULTS];
    logic [`REG_ADDR_LSB_W-1:0] res_off;
    logic                       res_hit;
    logic [31:0]                rd_data;

    assign req     = wbs_stb_i & wbs_cyc_i & ~wbs_ack_o;  // held request acked once
    assign wr_req  = req & wbs_we_i;
    assign rd_req  = req & ~wbs_we_i;
    assign reg_sel = reg_offset_e'(wbs_adr_i[`REG_ADDR_LSB_W-1:0]);

    assign start_ok = wr_req && reg_sel == REG_CTRL && wbs_dat_i == word_t'(1)
                      && base_a_set_q && base_b_set_q && state_q != HOST_RUN;

    assign res_wr = res_valid_i && state_q == HOST_RUN;

    // result window 0x0C..0x48, word aligned
    assign res_off = wbs_adr_i[`REG_ADDR_LSB_W-1:0] - `REG_RESULT_BASE;
    assign res_hit = wbs_adr_i[`REG_ADDR_LSB_W-1:0] >= `REG_RESULT_BASE
                     && res_off < 4 * `MM_RESULTS
                     && wbs_adr_i[1:0] == 2'b00;

    always_comb begin
        rd_data = '0;
        if (reg_sel == REG_CTRL) begin
            rd_data[2] = state_q != HOST_RUN;   // idle
            rd_data[1] = state_q == HOST_DONE;  // done
        end else if (res_hit && state_q == HOST_DONE) begin
            rd_data = res_mem[res_off[RES_IDX_W+1:2]];
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            wbs_ack_o    <= 1'b0;
            start_o      <= 1'b0;
            state_q      <= HOST_IDLE;
            base_a_set_q <= 1'b0;
            base_b_set_q <= 1'b0;
            res_idx_q    <= '0;
        end else begin
            wbs_ack_o <= req;
            start_o   <= start_ok;
            if (wr_req && reg_sel == REG_BASE_A) begin
                base_a_set_q <= 1'b1;
            end
            if (wr_req && reg_sel == REG_BASE_B) begin
                base_b_set_q <= 1'b1;
            end
            if (start_ok) begin
                state_q   <= HOST_RUN;
                res_idx_q <= '0;  // old results dropped
            end else if (res_wr) begin
                res_idx_q <= res_idx_q + 1'b1;
                if (res_idx_q == RES_IDX_W'(`MM_RESULTS - 1)) begin
                    state_q <= HOST_DONE;
                end
            end
        end
    end

    always_ff @(posedge wb_clk_i) begin
        wbs_dat_o <= rd_req ? rd_data : '0;
        if (wr_req && reg_sel == REG_BASE_A) begin
            base_a_q <= wbs_dat_i[`SDRAM_ADDR_W-1:0];
        end
        if (wr_req && reg_sel == REG_BASE_B) begin
            base_b_q <= wbs_dat_i[`SDRAM_ADDR_W-1:0];
        end
        if (res_wr) begin
            res_mem[res_idx_q] <= res_data_i;  // row-major arrival
        end
    end

    assign base_a_o = base_a_q;
    assign base_b_o = base_b_q;

endmodule

// File: design/sdram_fetch.sv
`timescale 1ns/100ps
`include "mm_dma_defs.svh"

module sdram_fetch (
    input  logic                       wb_clk_i,
    input  logic                       wb_rst_i,
    input  logic                       start_i,
    input  sdram_req_pkg::sdram_addr_t base_a_i,
    input  sdram_req_pkg::sdram_addr_t base_b_i,
    input  logic                       eng_busy_i,
    input  logic                       sdram_rd_valid_i,
    input  mm_dma_pkg::word_t          sdram_rd_data_i,
    output logic                       sdram_req_o,
    output sdram_req_pkg::sdram_addr_t sdram_addr_o,
    output logic                       sdram_prefetch_o,
    output logic                       grp_valid_o,
    output mm_dma_pkg::word_vec_t      grp_data_o
);
    import mm_dma_pkg::*;
    import sdram_req_pkg::*;

    localparam int GRP_W  = $clog2(`MM_GROUPS);
    localparam int ELEM_W = $clog2(`MM_DIM);

    fetch_state_e      state_q;
    logic [GRP_W-1:0]  grp_q;  // 0 A row 0, 1-4 B cols, 5-7 A rows 1-3
    logic [ELEM_W-1:0] elem_q;
    logic              is_b_grp;
    logic [ELEM_W-1:0] row_idx;
    logic [ELEM_W-1:0] col_idx;
    word_vec_t         grp_buf_q;

    assign is_b_grp = grp_q >= GRP_W'(1) && grp_q <= GRP_W'(`MM_DIM);
    assign row_idx  = ELEM_W'(grp_q - GRP_W'(`MM_DIM));  // group 0 wraps to row 0
    assign col_idx  = ELEM_W'(grp_q - 1'b1);

    always_comb begin
        if (is_b_grp) begin
            sdram_addr_o = base_b_i
                           + sdram_addr_t'(col_idx * `B_COL_STRIDE)
                           + sdram_addr_t'(elem_q * `B_ELEM_STRIDE);
        end else begin
            sdram_addr_o = base_a_i
                           + sdram_addr_t'(row_idx * `A_ROW_STRIDE)
                           + sdram_addr_t'(elem_q * `A_ELEM_STRIDE);
        end
    end

    assign sdram_req_o      = state_q == FETCH_ISSUE;
    assign sdram_prefetch_o = sdram_req_o & is_b_grp;  // hint for B columns
    assign grp_data_o       = grp_buf_q;

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            state_q     <= FETCH_IDLE;
            grp_q       <= '0;
            elem_q      <= '0;
            grp_valid_o <= 1'b0;
        end else begin
            grp_valid_o <= 1'b0;
            case (state_q)
                FETCH_IDLE, FETCH_DONE: begin
                    if (start_i) begin
                        grp_q   <= '0;
                        elem_q  <= '0;
                        state_q <= eng_busy_i ? FETCH_WAIT_ENGINE : FETCH_ISSUE;
                    end
                end
                FETCH_WAIT_ENGINE: begin
                    if (!eng_busy_i) begin
                        state_q <= FETCH_ISSUE;
                    end
                end
                FETCH_ISSUE: begin
                    state_q <= FETCH_WAIT_DATA;  // single read in flight
                end
                FETCH_WAIT_DATA: begin
                    if (sdram_rd_valid_i) begin
                        if (elem_q == ELEM_W'(`MM_DIM - 1)) begin
                            elem_q      <= '0;
                            grp_valid_o <= 1'b1;
                            if (grp_q == GRP_W'(`MM_GROUPS - 1)) begin
                                state_q <= FETCH_DONE;
                            end else begin
                                grp_q   <= grp_q + 1'b1;
                                state_q <= FETCH_WAIT_ENGINE;
                            end
                        end else begin
                            elem_q  <= elem_q + 1'b1;
                            state_q <= FETCH_ISSUE;
                        end
                    end
                end
                default: begin
                    state_q <= FETCH_IDLE;
                end
            endcase
        end
    end

    // returned words land by element index
    always_ff @(posedge wb_clk_i) begin
        if (state_q == FETCH_WAIT_DATA && sdram_rd_valid_i) begin
            grp_buf_q[elem_q] <= sdram_rd_data_i;
        end
    end

endmodule

// File: design/mm_engine.sv
`timescale 1ns/100ps
`include "mm_dma_defs.svh"

module mm_engine (
    input  logic                  wb_clk_i,
    input  logic                  wb_rst_i,
    input  logic                  grp_valid_i,
    input  mm_dma_pkg::word_vec_t grp_data_i,
    output logic                  eng_busy_o,
    output logic                  res_valid_o,
    output mm_dma_pkg::word_t     res_data_o
);
    import mm_dma_pkg::*;

    localparam int GRP_W = $clog2(`MM_GROUPS);
    localparam int COL_W = $clog2(`MM_DIM);
    localparam logic [GRP_W-1:0] LAST_B_GRP = GRP_W'(`MM_DIM);

    logic [GRP_W-1:0] grp_cnt_q;  // same group order as the fetch side
    logic             is_b_grp;
    logic             row_go;
    logic [COL_W-1:0] b_sel;
    logic             run_q;
    logic [COL_W-1:0] col_q;
    word_vec_t        a_row_q;
    word_vec_t        b_col_q [`MM_DIM];
    word_t            dot;

    assign is_b_grp = grp_cnt_q != '0 && grp_cnt_q <= LAST_B_GRP;
    assign b_sel    = COL_W'(grp_cnt_q - 1'b1);

    // last B column or any later A row completes the operands
    assign row_go = grp_valid_i && grp_cnt_q >= LAST_B_GRP;

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            grp_cnt_q <= '0;
            run_q     <= 1'b0;
            col_q     <= '0;
        end else begin
            if (grp_valid_i) begin
                grp_cnt_q <= grp_cnt_q + 1'b1;  // wraps after group 7
            end
            if (row_go) begin
                run_q <= 1'b1;
                col_q <= '0;
            end else if (run_q) begin
                col_q <= col_q + 1'b1;
                if (col_q == COL_W'(`MM_DIM - 1)) begin
                    run_q <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (grp_valid_i) begin
            if (is_b_grp) begin
                b_col_q[b_sel] <= grp_data_i;
            end else begin
                a_row_q <= grp_data_i;  // row 0 waits here for the B columns
            end
        end
    end

    // 4-term dot product, wraps at 32 bits
    always_comb begin
        dot = '0;
        for (int i = 0; i < `MM_DIM; i++) begin
            dot = dot + a_row_q[i] * b_col_q[col_q][i];
        end
    end

    assign res_valid_o = run_q;
    assign res_data_o  = dot;
    assign eng_busy_o  = grp_valid_i | run_q;

endmodule

// File: design/mm_dma_top.sv
`timescale 1ns/100ps

module mm_dma_top (
    input  logic                       wb_clk_i,
    input  logic                       wb_rst_i,
    input  logic                       wbs_stb_i,
    input  logic                       wbs_cyc_i,
    input  logic                       wbs_we_i,
    input  logic [31:0]                wbs_adr_i,
    input  mm_dma_pkg::word_t          wbs_dat_i,
    output logic                       wbs_ack_o,
    output logic [31:0]                wbs_dat_o,
    output logic                       sdram_req_o,
    output sdram_req_pkg::sdram_addr_t sdram_addr_o,
    output logic                       sdram_prefetch_o,
    input  logic                       sdram_rd_valid_i,
    input  mm_dma_pkg::word_t          sdram_rd_data_i
);
    import mm_dma_pkg::*;
    import sdram_req_pkg::*;

    logic        start;
    sdram_addr_t base_a;
    sdram_addr_t base_b;
    logic        grp_valid;
    word_vec_t   grp_data;
    logic        eng_busy;
    logic        res_valid;
    word_t       res_data;

    wb_ctrl_regs u_regs (
        .wb_clk_i    (wb_clk_i),
        .wb_rst_i    (wb_rst_i),
        .wbs_stb_i   (wbs_stb_i),
        .wbs_cyc_i   (wbs_cyc_i),
        .wbs_we_i    (wbs_we_i),
        .wbs_adr_i   (wbs_adr_i),
        .wbs_dat_i   (wbs_dat_i),
        .res_valid_i (res_valid),
        .res_data_i  (res_data),
        .wbs_ack_o   (wbs_ack_o),
        .wbs_dat_o   (wbs_dat_o),
        .start_o     (start),
        .base_a_o    (base_a),
        .base_b_o    (base_b)
    );

    sdram_fetch u_fetch (
        .wb_clk_i         (wb_clk_i),
        .wb_rst_i         (wb_rst_i),
        .start_i          (start),
        .base_a_i         (base_a),
        .base_b_i         (base_b),
        .eng_busy_i       (eng_busy),
        .sdram_rd_valid_i (sdram_rd_valid_i),
        .sdram_rd_data_i  (sdram_rd_data_i),
        .sdram_req_o      (sdram_req_o),
        .sdram_addr_o     (sdram_addr_o),
        .sdram_prefetch_o (sdram_prefetch_o),
        .grp_valid_o      (grp_valid),
        .grp_data_o       (grp_data)
    );

    mm_engine u_engine (
        .wb_clk_i    (wb_clk_i),
        .wb_rst_i    (wb_rst_i),
        .grp_valid_i (grp_valid),
        .grp_data_i  (grp_data),
        .eng_busy_o  (eng_busy),
        .res_valid_o (res_valid),
        .res_data_o  (res_data)
    );

endmodule

// File: dv/sdram_model.sv
`timescale 1ns/100ps
`include "mm_dma_defs.svh"

module sdram_model (
    input  logic                       wb_clk_i,
    input  logic                       wb_rst_i,
    input  logic                       sdram_req_i,
    input  sdram_req_pkg::sdram_addr_t sdram_addr_i,
    output logic                       sdram_rd_valid_o,
    output mm_dma_pkg::word_t          sdram_rd_data_o,
    output logic                       proto_err_o
);
    import mm_dma_pkg::*;
    import sdram_req_pkg::*;

    localparam int MEM_WORDS = 4096;  // 16 KB modeled
    localparam int IDX_W     = $clog2(MEM_WORDS);

    word_t       mem [MEM_WORDS];
    logic        busy_q;
    logic [2:0]  wait_q;
    sdram_addr_t addr_q;

    // unloaded words still tell where they came from
    function automatic word_t fill_word(input sdram_addr_t addr);
        return word_t'({9'h1A5, addr});
    endfunction

    function automatic logic [IDX_W-1:0] word_idx(input sdram_addr_t addr);
        return addr[IDX_W+1:2];
    endfunction

    task automatic load_word(input sdram_addr_t addr, input word_t data);
        mem[word_idx(addr)] = data;
    endtask

    initial begin
        busy_q           = 1'b0;
        wait_q           = '0;
        sdram_rd_valid_o = 1'b0;
        sdram_rd_data_o  = '0;
        proto_err_o      = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = fill_word(sdram_addr_t'(4 * i));
        end
    end

    always @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            busy_q           <= 1'b0;
            sdram_rd_valid_o <= 1'b0;
            proto_err_o      <= 1'b0;
        end else begin
            sdram_rd_valid_o <= 1'b0;
            if (sdram_req_i) begin
                if (busy_q || sdram_addr_i[1:0] != 2'b00
                    || sdram_addr_i >= sdram_addr_t'(4 * MEM_WORDS)) begin
                    proto_err_o <= 1'b1;  // sticky
                end
                busy_q <= 1'b1;
                addr_q <= sdram_addr_i;
                wait_q <= 3'($urandom % 6);  // 1 to 6 cycles in flight
            end else if (busy_q) begin
                if (wait_q == '0) begin
                    sdram_rd_valid_o <= 1'b1;
                    sdram_rd_data_o  <= mem[word_idx(addr_q)];
                    busy_q           <= 1'b0;
                end else begin
                    wait_q <= wait_q - 1'b1;
                end
            end
        end
    end

endmodule

// File: dv/mm_dma_tb.sv
`timescale 1ns/100ps
`include "mm_dma_defs.svh"

module mm_dma_tb;
    import mm_dma_pkg::*;
    import sdram_req_pkg::*;

    localparam int NUM_CASES   = 3;
    localparam int CASE_WORDS  = 2 + 3 * `MM_RESULTS;  // bases, A, B, C
    localparam int ACK_LIMIT   = 20;
    localparam int DONE_POLLS  = 400;
    localparam int IDLE_WINDOW = 50;
    localparam logic [31:0] CTRL_ADR  = 32'(REG_CTRL);
    localparam logic [31:0] STAT_IDLE = 32'h4;
    localparam logic [31:0] STAT_DONE = 32'h6;

    logic        wb_clk_i;
    logic        wb_rst_i;
    logic        wbs_stb;
    logic        wbs_cyc;
    logic        wbs_we;
    logic [31:0] wbs_adr;
    word_t       wbs_wdat;
    logic        wbs_ack;
    logic [31:0] wbs_rdat;
    logic        sdram_req;
    sdram_addr_t sdram_addr;
    logic        sdram_pf;
    logic        sdram_rd_valid;
    word_t       sdram_rd_data;
    logic        mem_err;
    logic [31:0] case_mem [NUM_CASES*CASE_WORDS];
    sdram_addr_t req_addr_q [$];
    logic        req_pf_q [$];

    mm_dma_top u_dut (
        .wb_clk_i         (wb_clk_i),
        .wb_rst_i         (wb_rst_i),
        .wbs_stb_i        (wbs_stb),
        .wbs_cyc_i        (wbs_cyc),
        .wbs_we_i         (wbs_we),
        .wbs_adr_i        (wbs_adr),
        .wbs_dat_i        (wbs_wdat),
        .wbs_ack_o        (wbs_ack),
        .wbs_dat_o        (wbs_rdat),
        .sdram_req_o      (sdram_req),
        .sdram_addr_o     (sdram_addr),
        .sdram_prefetch_o (sdram_pf),
        .sdram_rd_valid_i (sdram_rd_valid),
        .sdram_rd_data_i  (sdram_rd_data)
    );

    sdram_model u_mem (
        .wb_clk_i         (wb_clk_i),
        .wb_rst_i         (wb_rst_i),
        .sdram_req_i      (sdram_req),
        .sdram_addr_i     (sdram_addr),
        .sdram_rd_valid_o (sdram_rd_valid),
        .sdram_rd_data_o  (sdram_rd_data),
        .proto_err_o      (mem_err)
    );

    initial begin
        wb_clk_i = 1'b0;
        forever #2 wb_clk_i = ~wb_clk_i;
    end

    always @(negedge wb_clk_i) begin
        if (sdram_req) begin  // one-cycle strobe, one entry
            req_addr_q.push_back(sdram_addr);
            req_pf_q.push_back(sdram_pf);
        end
    end

    task automatic abort_run();
        $display("Result: FAILED");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic flag_mismatch(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        abort_run();
    endtask

    task automatic flag_problem(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        abort_run();
    endtask

    task automatic wb_access(input logic we, input logic [31:0] adr,
                             input logic [31:0] wdat, output logic [31:0] rdat);
        int n;
        @(posedge wb_clk_i);
        wbs_stb  <= 1'b1;
        wbs_cyc  <= 1'b1;
        wbs_we   <= we;
        wbs_adr  <= adr;
        wbs_wdat <= wdat;
        n = 0;
        do begin
            @(negedge wb_clk_i);
            n++;
        end while (!wbs_ack && n < ACK_LIMIT);
        if (!wbs_ack) flag_problem($sformatf("no ack for access to offset 0x%02h", adr));
        assert (n == 2) else
            flag_mismatch($sformatf("ack at 0x%02h after %0d cycles", adr, n - 1));
        rdat = wbs_rdat;
        @(posedge wb_clk_i);
        wbs_stb <= 1'b0;
        wbs_cyc <= 1'b0;
        wbs_we  <= 1'b0;
        @(negedge wb_clk_i);
        assert (!wbs_ack) else flag_mismatch($sformatf("second ack at 0x%02h", adr));
    endtask

    task automatic wb_write(input logic [31:0] adr, input logic [31:0] wdat);
        logic [31:0] unused;
        wb_access(1'b1, adr, wdat, unused);
    endtask

    task automatic expect_read(input logic [31:0] adr, input logic [31:0] exp,
                               input string what);
        logic [31:0] got;
        wb_access(1'b0, adr, '0, got);
        assert (got === exp) else
            flag_mismatch($sformatf("%s, offset 0x%02h read 0x%08h, expected 0x%08h",
                                    what, adr, got, exp));
    endtask

    // stride rule for group g, element e
    function automatic sdram_addr_t expected_addr(input sdram_addr_t a, input sdram_addr_t b,
                                                  input int g, input int e);
        if (g == 0) return a + sdram_addr_t'(`A_ELEM_STRIDE * e);
        if (g <= `MM_DIM) return b + sdram_addr_t'(`B_COL_STRIDE * (g - 1) + `B_ELEM_STRIDE * e);
        return a + sdram_addr_t'(`A_ROW_STRIDE * (g - `MM_DIM) + `A_ELEM_STRIDE * e);
    endfunction

    task automatic load_case(input int base);
        sdram_addr_t a;
        sdram_addr_t b;
        a = sdram_addr_t'(case_mem[base]);
        b = sdram_addr_t'(case_mem[base + 1]);
        for (int r = 0; r < `MM_DIM; r++) begin
            for (int c = 0; c < `MM_DIM; c++) begin
                u_mem.load_word(a + sdram_addr_t'(`A_ROW_STRIDE * r + `A_ELEM_STRIDE * c),
                                case_mem[base + 2 + 4 * r + c]);
                u_mem.load_word(b + sdram_addr_t'(`B_ELEM_STRIDE * r + `B_COL_STRIDE * c),
                                case_mem[base + 18 + 4 * r + c]);  // B row-major in file
            end
        end
    endtask

    task automatic check_requests(input int base);
        sdram_addr_t exp;
        int idx;
        assert (req_addr_q.size() == 4 * `MM_GROUPS) else
            flag_mismatch($sformatf("%0d sdram requests seen", req_addr_q.size()));
        for (int g = 0; g < `MM_GROUPS; g++) begin
            for (int e = 0; e < `MM_DIM; e++) begin
                idx = 4 * g + e;
                exp = expected_addr(sdram_addr_t'(case_mem[base]),
                                    sdram_addr_t'(case_mem[base + 1]), g, e);
                assert (req_addr_q[idx] == exp) else
                    flag_mismatch($sformatf("request %0d addr 0x%06h, expected 0x%06h",
                                            idx, req_addr_q[idx], exp));
                assert (req_pf_q[idx] == (g >= 1 && g <= `MM_DIM)) else
                    flag_mismatch($sformatf("request %0d prefetch hint %0b", idx, req_pf_q[idx]));
            end
        end
    endtask

    task automatic wait_for_done(input int case_no);
        logic [31:0] stat;
        int polls;
        stat  = '0;
        polls = 0;
        while (!stat[1] && polls < DONE_POLLS) begin
            wb_access(1'b0, CTRL_ADR, '0, stat);
            polls++;
        end
        if (!stat[1]) flag_problem($sformatf("case %0d never reached done", case_no));
        assert (stat == STAT_DONE) else
            flag_mismatch($sformatf("case %0d status 0x%08h at done", case_no, stat));
    endtask

    task automatic run_case(input int i);
        int base;
        base = i * CASE_WORDS;
        load_case(base);
        req_addr_q.delete();
        req_pf_q.delete();
        wb_write(32'(REG_BASE_A), case_mem[base]);
        wb_write(32'(REG_BASE_B), case_mem[base + 1]);
        wb_write(CTRL_ADR, 32'h1);
        expect_read(CTRL_ADR, 32'h0, "status while running");
        if (i > 0) expect_read(`REG_RESULT_BASE, 32'h0, "old result after restart");
        wait_for_done(i);
        for (int k = 0; k < `MM_RESULTS; k++) begin
            expect_read(`REG_RESULT_BASE + 4 * k, case_mem[base + 34 + k],
                        $sformatf("case %0d C[%0d][%0d]", i, k / 4, k % 4));
        end
        check_requests(base);
        expect_read(32'h80, 32'h0, "unmapped offset");
        assert (!mem_err) else flag_problem("sdram model saw overlapping or bad requests");
    endtask

    initial begin
        void'($urandom(44));
        wb_rst_i = 1'b1;
        wbs_stb  = 1'b0;
        wbs_cyc  = 1'b0;
        wbs_we   = 1'b0;
        wbs_adr  = '0;
        wbs_wdat = '0;
        $readmemh("dv/mm_dma_cases.txt", case_mem);
        if (case_mem[NUM_CASES*CASE_WORDS-1] === 'x) flag_problem("case file missing or short");
        repeat (4) @(posedge wb_clk_i);
        wb_rst_i <= 1'b0;

        expect_read(CTRL_ADR, STAT_IDLE, "status after reset");
        wb_write(CTRL_ADR, 32'h1);  // no bases yet
        expect_read(CTRL_ADR, STAT_IDLE, "status after refused start");
        wb_write(32'(REG_BASE_A), 32'h100);
        wb_write(CTRL_ADR, 32'h1);  // base B still missing
        expect_read(CTRL_ADR, STAT_IDLE, "status after start with base A only");
        repeat (IDLE_WINDOW) @(negedge wb_clk_i);
        assert (req_addr_q.size() == 0) else flag_mismatch("sdram request after refused start");

        for (int i = 0; i < NUM_CASES; i++) begin
            run_case(i);
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: dv/mm_dma_cases.txt
// per case: base_a base_b, then A, B and expected C, each row-major, 16 words
// B row e sits at base_b + 16e, C wraps at 32 bits signed
// case 0, small positives
00000100 00000200
00000001 00000002 00000003 00000004 00000005 00000006 00000007 00000008
00000009 0000000A 0000000B 0000000C 0000000D 0000000E 0000000F 00000010
00000001 00000000 00000000 00000001 00000000 00000001 00000000 00000002
00000000 00000000 00000001 00000003 00000001 00000001 00000001 00000001
00000005 00000006 00000007 00000012 0000000D 0000000E 0000000F 0000002E
00000015 00000016 00000017 0000004A 0000001D 0000001E 0000001F 00000066
// case 1, mixed signs
00001000 00000840
FFFFFFFF 00000002 FFFFFFFD 00000004 00000000 FFFFFFFB 00000006 00000000
00000007 00000000 00000000 FFFFFFF8 FFFFFFFE FFFFFFFE FFFFFFFE FFFFFFFE
00000002 FFFFFFFF 00000000 00000003 00000001 00000001 FFFFFFFC 00000000
00000000 FFFFFFFE 00000005 00000001 FFFFFFFD 00000000 00000001 FFFFFFFF
FFFFFFF4 00000009 FFFFFFED FFFFFFF6 FFFFFFFB FFFFFFEF 00000032 00000006
00000026 FFFFFFF9 FFFFFFF8 0000001D 00000000 00000004 FFFFFFFC FFFFFFFA
// case 2, products and sums that overflow
00003F00 00001230
40000000 40000000 00000000 00000000 7FFFFFFF 00000001 00000000 00000000
00010000 00010000 00010000 00010000 FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF
00000002 00000001 00000000 00000003 00000002 00000000 00000001 00000000
00010000 00000000 00000000 00000000 00000000 00000000 00000000 FFFFFFFF
00000000 40000000 40000000 C0000000 00000000 7FFFFFFF 00000001 7FFFFFFD
00040000 00010000 00010000 00020000 FFFEFFFC FFFFFFFF FFFFFFFF FFFFFFFE

// File: build.f
+incdir+include
design/mm_dma_pkg.sv
design/sdram_req_pkg.sv
design/wb_ctrl_regs.sv
design/sdram_fetch.sv
design/mm_engine.sv
design/mm_dma_top.sv
dv/sdram_model.sv
dv/mm_dma_tb.sv

// File: Bender.yml
package:
  name: mm_dma

sources:
  - include_dirs:
      - include
    files:
      - design/mm_dma_pkg.sv
      - design/sdram_req_pkg.sv
      - design/wb_ctrl_regs.sv
      - design/sdram_fetch.sv
      - design/mm_engine.sv
      - design/mm_dma_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/sdram_model.sv
      - dv/mm_dma_tb.sv
